// ==== verilog/rv_pipe_pkg.sv ====
// Shared widths, word types, RV32I opcode and funct3 codes
// ALU function codes and operand select codes for the ALU pipeline

`default_nettype none

package rv_pipe_pkg;

  //----------------------------------------
  // Widths and word types
  //----------------------------------------

  localparam int xlen    = 32;
  localparam int shamt_w = 5;   // Low bits of operand 1 used by shifts

  typedef logic [xlen-1:0] word_t;      // Data and instruction word
  typedef logic [4:0]      reg_addr_t;  // Register specifier
  typedef logic [6:0]      opcode_t;    // inst[6:0]
  typedef logic [2:0]      funct3_t;    // inst[14:12]
  typedef logic [3:0]      alu_fn_t;
  typedef logic            op0_sel_t;
  typedef logic            op1_sel_t;

  //----------------------------------------
  // Opcodes and funct3 codes
  //----------------------------------------

  localparam opcode_t opc_op     = 7'b0110011;  // Register-register
  localparam opcode_t opc_op_imm = 7'b0010011;  // Register-immediate
  localparam opcode_t opc_lui    = 7'b0110111;

  localparam funct3_t f3_add_sub = 3'b000;
  localparam funct3_t f3_sll     = 3'b001;
  localparam funct3_t f3_slt     = 3'b010;
  localparam funct3_t f3_sltu    = 3'b011;
  localparam funct3_t f3_xor     = 3'b100;
  localparam funct3_t f3_srl_sra = 3'b101;  // inst[30] picks arithmetic
  localparam funct3_t f3_or      = 3'b110;
  localparam funct3_t f3_and     = 3'b111;

  // ALU function codes
  localparam alu_fn_t alu_add  = 4'd0;
  localparam alu_fn_t alu_sub  = 4'd1;
  localparam alu_fn_t alu_sll  = 4'd2;
  localparam alu_fn_t alu_or   = 4'd3;
  localparam alu_fn_t alu_slt  = 4'd4;
  localparam alu_fn_t alu_sltu = 4'd5;
  localparam alu_fn_t alu_and  = 4'd6;
  localparam alu_fn_t alu_xor  = 4'd7;
  localparam alu_fn_t alu_srl  = 4'd9;
  localparam alu_fn_t alu_sra  = 4'd10;

  // Operand selects
  localparam op0_sel_t op0_rs1  = 1'b0;  // Forwarded rs1 value
  localparam op0_sel_t op0_zero = 1'b1;  // Constant zero, for LUI
  localparam op1_sel_t op1_rs2  = 1'b0;  // Forwarded rs2 value
  localparam op1_sel_t op1_imm  = 1'b1;  // I or U immediate

endpackage

`default_nettype wire

// ==== verilog/rv_inst_decode.sv ====
// Instruction decoder for the RV32I ALU subset
// Register fields, immediate, ALU function and operand selects

`default_nettype none

module rv_inst_decode import rv_pipe_pkg::*; (
  input  word_t     inst,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output reg_addr_t rd,
  output word_t     imm,
  output alu_fn_t   alu_fn,
  output op0_sel_t  op0_sel,
  output op1_sel_t  op1_sel
);

  opcode_t opcode;
  funct3_t funct3;
  logic    alt;     // funct7 bit 5, marks SUB and SRA
  word_t   imm_i;
  word_t   imm_u;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign alt    = inst[30];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};  // Sign extended
  assign imm_u = {inst[31:12], 12'b0};

  always_comb begin
    // Defaults cover OP-IMM
    imm     = imm_i;
    op0_sel = op0_rs1;
    op1_sel = op1_imm;
    alu_fn  = alu_add;
    if (opcode == opc_lui) begin
      imm     = imm_u;
      op0_sel = op0_zero;  // 0 + U immediate
    end else begin
      if (opcode == opc_op)
        op1_sel = op1_rs2;
      case (funct3)
        f3_add_sub: alu_fn = (opcode == opc_op && alt) ? alu_sub : alu_add;
        f3_sll:     alu_fn = alu_sll;
        f3_slt:     alu_fn = alu_slt;
        f3_sltu:    alu_fn = alu_sltu;
        f3_xor:     alu_fn = alu_xor;
        f3_srl_sra: alu_fn = alt ? alu_sra : alu_srl;  // Both forms
        f3_or:      alu_fn = alu_or;
        f3_and:     alu_fn = alu_and;
        default:    alu_fn = alu_add;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rv_regfile.sv ====
// Register file, 31 x 32-bit plus hardwired x0
// Two combinational read ports, one clocked write port

`default_nettype none

module rv_regfile import rv_pipe_pkg::*; (
  input  wire       clk,
  input  reg_addr_t raddr0,
  output word_t     rdata0,
  input  reg_addr_t raddr1,
  output word_t     rdata1,
  input  wire       wen,
  input  reg_addr_t waddr,
  input  word_t     wdata
);

  word_t regs [1:31];  // No storage for x0

  // x0 always reads zero
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

  always_ff @(posedge clk) begin
    if (wen && waddr != '0)  // Guard keeps x0 out of the array
      regs[waddr] <= wdata;
  end

endmodule

`default_nettype wire

// ==== verilog/rv_alu.sv ====
// Combinational ALU for the RV32I integer subset

`default_nettype none

module rv_alu import rv_pipe_pkg::*; (
  input  word_t   in0,
  input  word_t   in1,
  input  alu_fn_t fn,
  output word_t   out
);

  logic [shamt_w-1:0] shamt;

  assign shamt = in1[shamt_w-1:0];  // Upper bits ignored

  always_comb begin
    case (fn)
      alu_add:  out = in0 + in1;
      alu_sub:  out = in0 - in1;
      alu_sll:  out = in0 << shamt;
      alu_slt:  out = {31'b0, $signed(in0) < $signed(in1)};
      alu_sltu: out = {31'b0, in0 < in1};
      alu_xor:  out = in0 ^ in1;
      alu_srl:  out = in0 >> shamt;
      alu_sra:  out = word_t'($signed(in0) >>> shamt);  // Sign fill
      alu_or:   out = in0 | in1;
      alu_and:  out = in0 & in1;
      default:  out = '0;  // Unused codes
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/rv_decode_stage.sv ====
// Decode stage: D register, register read, forwarding from X and W
// and the two operand muxes feeding the execute stage

`default_nettype none

module rv_decode_stage import rv_pipe_pkg::*; (
  input  wire       clk,
  input  wire       reset,
  input  wire       stall,
  input  wire       inst_valid,
  input  word_t     inst,
  output reg_addr_t rf_raddr0,
  output reg_addr_t rf_raddr1,
  input  word_t     rf_rdata0,
  input  word_t     rf_rdata1,
  input  wire       x_fwd_valid,
  input  reg_addr_t x_fwd_rd,
  input  word_t     x_fwd_data,
  input  wire       w_fwd_valid,
  input  reg_addr_t w_fwd_rd,
  input  word_t     w_fwd_data,
  output logic      d_valid,
  output reg_addr_t d_rd,
  output alu_fn_t   d_alu_fn,
  output word_t     d_op0,
  output word_t     d_op1
);

  word_t    inst_q;  // Held instruction
  word_t    imm;
  op0_sel_t op0_sel;
  op1_sel_t op1_sel;
  word_t    rs1_val;
  word_t    rs2_val;

  // Newest value of a source, X before W before the register file
  function automatic word_t fwd_pick(input reg_addr_t src, input word_t rf_val);
    word_t val;
    val = rf_val;
    if (w_fwd_valid && w_fwd_rd != '0 && w_fwd_rd == src)
      val = w_fwd_data;
    if (x_fwd_valid && x_fwd_rd != '0 && x_fwd_rd == src)
      val = x_fwd_data;  // Younger result wins
    return val;
  endfunction

  //----------------------------------------
  // D register
  //----------------------------------------

  always_ff @(posedge clk) begin
    if (reset)
      d_valid <= 1'b0;
    else if (!stall)
      d_valid <= inst_valid;  // Bubble when nothing offered
  end

  always_ff @(posedge clk) begin
    if (!stall)
      inst_q <= inst;
  end

  rv_inst_decode u_decode (
    .inst    (inst_q),
    .rs1     (rf_raddr0),
    .rs2     (rf_raddr1),
    .rd      (d_rd),
    .imm     (imm),
    .alu_fn  (d_alu_fn),
    .op0_sel (op0_sel),
    .op1_sel (op1_sel)
  );

  always_comb begin
    rs1_val = fwd_pick(rf_raddr0, rf_rdata0);
    rs2_val = fwd_pick(rf_raddr1, rf_rdata1);
  end

  // Operand muxes
  assign d_op0 = (op0_sel == op0_zero) ? '0  : rs1_val;
  assign d_op1 = (op1_sel == op1_imm)  ? imm : rs2_val;

endmodule

`default_nettype wire

// ==== verilog/rv_execute_stage.sv ====
// Execute stage: X register and ALU, then the W register
// that drives the writeback stream

`default_nettype none

module rv_execute_stage import rv_pipe_pkg::*; (
  input  wire       clk,
  input  wire       reset,
  input  wire       stall,
  input  wire       d_valid,
  input  reg_addr_t d_rd,
  input  alu_fn_t   d_alu_fn,
  input  word_t     d_op0,
  input  word_t     d_op1,
  output logic      x_valid,
  output reg_addr_t x_rd,
  output word_t     x_result,
  output logic      wb_valid,
  output reg_addr_t wb_rd,
  output word_t     wb_data
);

  alu_fn_t x_fn;
  word_t   x_op0;
  word_t   x_op1;

  //----------------------------------------
  // X register
  //----------------------------------------

  always_ff @(posedge clk) begin
    if (reset)
      x_valid <= 1'b0;
    else if (!stall)
      x_valid <= d_valid;
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      x_rd  <= d_rd;
      x_fn  <= d_alu_fn;
      x_op0 <= d_op0;
      x_op1 <= d_op1;
    end
  end

  rv_alu u_alu (
    .in0 (x_op0),
    .in1 (x_op1),
    .fn  (x_fn),
    .out (x_result)  // Also the X forwarding value
  );

  //----------------------------------------
  // W register
  //----------------------------------------

  // Held while the sink is not ready
  always_ff @(posedge clk) begin
    if (reset)
      wb_valid <= 1'b0;
    else if (!stall)
      wb_valid <= x_valid;
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      wb_rd   <= x_rd;
      wb_data <= x_result;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rv_alu_pipe.sv ====
// Three-stage RV32I ALU pipeline top level
// Decode and execute stages, register file, stall and write enable

`default_nettype none

module rv_alu_pipe import rv_pipe_pkg::*; (
  input  wire       clk,
  input  wire       reset,
  input  wire       inst_valid,
  input  word_t     inst,
  output logic      inst_ready,
  output logic      wb_valid,
  output reg_addr_t wb_rd,
  output word_t     wb_data,
  input  wire       wb_ready
);

  logic      stall;
  logic      rf_wen;
  reg_addr_t rf_raddr0;
  reg_addr_t rf_raddr1;
  word_t     rf_rdata0;
  word_t     rf_rdata1;
  logic      d_valid;
  reg_addr_t d_rd;
  alu_fn_t   d_alu_fn;
  word_t     d_op0;
  word_t     d_op1;
  logic      x_valid;
  reg_addr_t x_rd;
  word_t     x_result;

  assign stall      = wb_valid && !wb_ready;  // Whole pipe freezes
  assign inst_ready = !stall;
  assign rf_wen     = wb_valid && wb_ready && (wb_rd != '0);  // x0 reported, not written

  rv_decode_stage u_dstage (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .rf_raddr0   (rf_raddr0),
    .rf_raddr1   (rf_raddr1),
    .rf_rdata0   (rf_rdata0),
    .rf_rdata1   (rf_rdata1),
    .x_fwd_valid (x_valid),
    .x_fwd_rd    (x_rd),
    .x_fwd_data  (x_result),
    .w_fwd_valid (wb_valid),
    .w_fwd_rd    (wb_rd),
    .w_fwd_data  (wb_data),
    .d_valid     (d_valid),
    .d_rd        (d_rd),
    .d_alu_fn    (d_alu_fn),
    .d_op0       (d_op0),
    .d_op1       (d_op1)
  );

  rv_execute_stage u_xstage (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .d_valid  (d_valid),
    .d_rd     (d_rd),
    .d_alu_fn (d_alu_fn),
    .d_op0    (d_op0),
    .d_op1    (d_op1),
    .x_valid  (x_valid),
    .x_rd     (x_rd),
    .x_result (x_result),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  rv_regfile u_rf (
    .clk    (clk),
    .raddr0 (rf_raddr0),
    .rdata0 (rf_rdata0),
    .raddr1 (rf_raddr1),
    .rdata1 (rf_rdata1),
    .wen    (rf_wen),
    .waddr  (wb_rd),
    .wdata  (wb_data)
  );

endmodule

`default_nettype wire

// ==== test/tb_rv_alu_pipe.sv ====
// Testbench for the RV32I ALU pipeline
// File-driven instructions, LFSR handshake noise, in-order writeback checks

`default_nettype none

module tb_rv_alu_pipe import rv_pipe_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          clk_half     = 5;        // 10 ns period
  localparam int          reset_cycles = 16;
  localparam logic [15:0] lfsr_seed    = 16'd16052;
  localparam logic [15:0] lfsr_taps    = 16'hB400;  // x^16 + x^14 + x^13 + x^11 + 1

  logic      clk;
  logic      reset;
  logic      inst_valid;
  word_t     inst;
  logic      inst_ready;
  logic      wb_valid;
  reg_addr_t wb_rd;
  word_t     wb_data;
  logic      wb_ready;

  word_t       test_inst [$];  // One entry per data file line
  reg_addr_t   test_rd   [$];
  word_t       test_data [$];
  int          n_tests;
  int          send_idx;     // Next instruction to offer
  int          recv_idx;     // Next expected writeback
  int          cycle_count;
  int          cycle_limit;
  logic        driving;
  logic        took_inst;    // Transfer at the last rising edge
  logic        held;         // Writeback stalled at the last edge
  reg_addr_t   held_rd;
  word_t       held_data;
  logic [15:0] lfsr;

  rv_alu_pipe UUT (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_ready (inst_ready),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .wb_ready   (wb_ready)
  );

  //----------------------------------------
  // Helpers
  //----------------------------------------

  function automatic logic [15:0] galois_step(input logic [15:0] s);
    return (s >> 1) ^ (s[0] ? lfsr_taps : 16'h0000);
  endfunction

  // One LFSR step per bit
  task automatic random_bit(output logic b);
    b    = lfsr[0];
    lfsr = galois_step(lfsr);
  endtask

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    stop_with_failure();
  endtask

  task automatic report_mismatch(input string name, input word_t expected,
                                 input word_t actual);
    $display("ERR at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    stop_with_failure();
  endtask

  // Reads instruction, rd and data columns and skips comment lines
  task automatic read_tests();
    int               fd;
    int               n;
    logic [8*128-1:0] line;
    word_t            f_inst;
    word_t            f_rd;
    word_t            f_data;
    fd = $fopen("test/rv_pipe_tests.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the test data file test/rv_pipe_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        n    = $fgets(line, fd);
        if (n > 0 && $sscanf(line, "%h %h %h", f_inst, f_rd, f_data) == 3) begin
          test_inst.push_back(f_inst);
          test_rd.push_back(f_rd[4:0]);
          test_data.push_back(f_data);
        end
      end
      $fclose(fd);
    end
  endtask

  // Compares against the next expected entry in program order
  task automatic check_writeback();
    if (recv_idx >= n_tests) begin
      abort_run("A writeback arrived after the last expected result");
    end else begin
      assert (wb_rd === test_rd[recv_idx])
        else report_mismatch("wb_rd", test_rd[recv_idx], wb_rd);
      assert (wb_data === test_data[recv_idx])
        else report_mismatch("wb_data", test_data[recv_idx], wb_data);
      recv_idx++;
    end
  endtask

  //----------------------------------------
  // Clock, reset and run control
  //----------------------------------------

  initial begin
    clk = 1'b0;
    forever #clk_half clk = ~clk;
  end

  initial begin
    send_idx    = 0;
    recv_idx    = 0;
    cycle_count = 0;
    driving     = 1'b0;
    took_inst   = 1'b0;
    held        = 1'b0;
    held_rd     = '0;
    held_data   = '0;
    lfsr        = lfsr_seed;
    reset       = 1'b1;
    inst_valid  = 1'b0;
    inst        = '0;
    wb_ready    = 1'b0;
    read_tests();
    n_tests     = test_inst.size();
    cycle_limit = n_tests * 8 + 100;
    if (n_tests == 0)
      abort_run("The test data file holds no tests");
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    // Idle pipe before the first instruction
    assert (wb_valid === 1'b0) else report_mismatch("wb_valid", 0, wb_valid);
    assert (inst_ready === 1'b1) else report_mismatch("inst_ready", 1, inst_ready);
    @(posedge clk);
    driving = 1'b1;  // First offer on the next falling edge
    wait (recv_idx == n_tests);
    repeat (4) @(posedge clk);  // Room for a duplicate to show up
    // Drained pipe holds nothing in W
    assert (wb_valid === 1'b0)
      else abort_run("A writeback was still pending after the last expected result");
    $display("Done: no errors");
    $finish;
  end

  //----------------------------------------
  // Stimulus on the falling edge
  //----------------------------------------

  always @(negedge clk) begin
    logic b0;
    logic b1;
    if (driving) begin
      // Offer stays up until taken
      if (!inst_valid || took_inst) begin
        random_bit(b0);
        random_bit(b1);
        inst_valid = (send_idx < n_tests) && (b0 || b1);  // About 3 in 4
      end
      inst = (send_idx < n_tests) ? test_inst[send_idx] : '0;
      random_bit(b0);
      wb_ready = b0;  // Half the cycles back-pressured
    end
  end

  // Handshakes, stability and timeout on the rising edge
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit && recv_idx < n_tests)
      abort_run($sformatf("Timeout: results stopped arriving, %0d of %0d after %0d cycles",
                          recv_idx, n_tests, cycle_count));
    if (!reset) begin
      took_inst = inst_valid && inst_ready;
      if (took_inst)
        send_idx++;
      if (held) begin
        assert (wb_valid === 1'b1) else report_mismatch("wb_valid", 1, wb_valid);
        assert (wb_rd === held_rd) else report_mismatch("wb_rd", held_rd, wb_rd);
        assert (wb_data === held_data) else report_mismatch("wb_data", held_data, wb_data);
      end
      if (wb_valid && wb_ready)
        check_writeback();
      held      = wb_valid && !wb_ready;
      held_rd   = wb_rd;
      held_data = wb_data;
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/rv_pipe_pkg.sv
verilog/rv_inst_decode.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_decode_stage.sv
verilog/rv_execute_stage.sv
verilog/rv_alu_pipe.sv
test/tb_rv_alu_pipe.sv

// ==== Bender.yml ====
package:
  name: rv_alu_pipe

sources:
  - verilog/rv_pipe_pkg.sv
  - verilog/rv_inst_decode.sv
  - verilog/rv_regfile.sv
  - verilog/rv_alu.sv
  - verilog/rv_decode_stage.sv
  - verilog/rv_execute_stage.sv
  - verilog/rv_alu_pipe.sv
  - target: test
    files:
      - test/tb_rv_alu_pipe.sv

// ==== test/rv_pipe_tests.txt ====
// inst     rd  data      one instruction per line, all hex
// rd and data are the expected writeback, in program order
00500093 01 00000005  // addi x1, x0, 5
00708093 01 0000000C  // addi x1, x1, 7
FFD08093 01 00000009  // addi x1, x1, -3
06408093 01 0000006D  // addi x1, x1, 100
80000137 02 80000000  // lui  x2, 0x80000
FF000193 03 FFFFFFF0  // addi x3, x0, -16
00308233 04 0000005D  // add  x4, x1, x3
403082B3 05 0000007D  // sub  x5, x1, x3
00400393 07 00000004  // addi x7, x0, 4
4071D333 06 FFFFFFFF  // sra  x6, x3, x7
0071D433 08 0FFFFFFF  // srl  x8, x3, x7
41F15493 09 FFFFFFFF  // srai x9, x2, 31
01F15513 0A 00000001  // srli x10, x2, 31
0011A5B3 0B 00000001  // slt  x11, x3, x1
0011B633 0C 00000000  // sltu x12, x3, x1
00012693 0D 00000001  // slti x13, x2, 0
FFF13713 0E 00000001  // sltiu x14, x2, -1
0030C7B3 0F FFFFFF9D  // xor  x15, x1, x3
00A3E833 10 00000005  // or   x16, x7, x10
0030F8B3 11 00000060  // and  x17, x1, x3
00709933 12 000006D0  // sll  x18, x1, x7
01C09993 13 D0000000  // slli x19, x1, 28
FFF0CA13 14 FFFFFF92  // xori x20, x1, -1
00F1EA93 15 FFFFFFFF  // ori  x21, x3, 15
7FF1FB13 16 000007F0  // andi x22, x3, 0x7ff
00108013 00 0000006E  // addi x0, x1, 1
00000BB3 17 00000000  // add  x23, x0, x0
40100C33 18 FFFFFF93  // sub  x24, x0, x1
12345CB7 19 12345000  // lui  x25, 0x12345
678C8C93 19 12345678  // addi x25, x25, 0x678
019C8D33 1A 2468ACF0  // add  x26, x25, x25
419D0DB3 1B 12345678  // sub  x27, x26, x25
00312E33 1C 00000001  // slt  x28, x2, x3
0021BEB3 1D 00000000  // sltu x29, x3, x2
41915F33 1E FFFFFF80  // sra  x30, x2, x25
01915FB3 1F 00000080  // srl  x31, x2, x25
